//--- verilog/glay_params.svh
// sizing macros shared by the whole design
// GLAY_NUM_REQ counts the engines plus one host requester, which takes the last index
`ifndef GLAY_PARAMS_SVH
`define GLAY_PARAMS_SVH

// edge-sum engines behind the arbiter
`define GLAY_NUM_ENGINES 3
`define GLAY_NUM_REQ (`GLAY_NUM_ENGINES + 1)

// edge memory is 2**GLAY_MEM_AW words deep
`define GLAY_MEM_AW 8
`define GLAY_DATA_W 32

// host side, bit 12 set selects the edge memory window
`define GLAY_AXI_AW 16
`define GLAY_MEM_WIN_BIT 12

`endif

//--- verilog/glay_pkg.sv
// shared types, widths come from glay_params.svh
`include "glay_params.svh"

package glay_pkg;

    // data words, edge weights and sums
    typedef logic [`GLAY_DATA_W-1:0] word_t;

    // word address into the edge memory
    typedef logic [`GLAY_MEM_AW-1:0] mem_addr_t;

    // axi4-lite byte address
    typedef logic [`GLAY_AXI_AW-1:0] axi_addr_t;

    // requester index at the arbiter
    typedef logic [$clog2(`GLAY_NUM_REQ)-1:0] eng_sel_t;

    typedef enum logic [1:0] {
        eng_idle,
        eng_issue,
        eng_wait_data,
        eng_done
    } eng_state_t;

    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_mem_wait,
        ctrl_resp
    } ctrl_state_t;

endpackage : glay_pkg

//--- verilog/glay_mem_if.sv
// one requester's port onto the shared edge memory
// req, we, addr and wdata hold until grant; rvalid comes two cycles after grant

interface glay_mem_if;

    // requester side
    logic                req;
    logic                we;
    glay_pkg::mem_addr_t addr;
    glay_pkg::word_t     wdata;

    // arbiter side
    logic                grant;
    logic                rvalid;
    glay_pkg::word_t     rdata;

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  grant,
        input  rvalid,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output grant,
        output rvalid,
        output rdata
    );

endinterface : glay_mem_if

//--- verilog/rr_arbiter.sv
// round-robin arbiter with a combinational grant
// the search starts one past the last granted index, so no requester starves
`include "glay_params.svh"

module rr_arbiter (
    input  logic                     ap_clk,
    input  logic                     areset,
    input  logic                     enable,
    input  logic [`GLAY_NUM_REQ-1:0] req,
    output logic [`GLAY_NUM_REQ-1:0] grant,
    output glay_pkg::eng_sel_t       select,
    output logic                     valid
);
    import glay_pkg::*;

    // index granted last
    eng_sel_t ptr;

    // walk the ring from ptr+1, the first request found wins
    always_comb begin
        int idx;
        grant  = '0;
        select = '0;
        valid  = 1'b0;
        for (int k = 1; k <= `GLAY_NUM_REQ; k++) begin
            idx = (int'(ptr) + k) % `GLAY_NUM_REQ;
            if (enable && !valid && req[idx]) begin
                grant[idx] = 1'b1;
                select     = eng_sel_t'(idx);
                valid      = 1'b1;
            end
        end
    end

    // first search after reset begins at requester 0
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            ptr <= eng_sel_t'(`GLAY_NUM_REQ - 1);
        end else if (valid) begin
            ptr <= select;
        end
    end

    // at most one winner and it must be asking
    a_grant_in_req : assert property (
        @(posedge ap_clk) disable iff (areset)
        $onehot0(grant) && ((grant & ~req) == '0)
    );

endmodule : rr_arbiter

//--- verilog/bus_arbiter_n_in_1_out.sv
// registered memory-bus mux for all requesters
// a requester can win at most every other cycle, its own grant masks it for one cycle
`include "glay_params.svh"

module bus_arbiter_n_in_1_out (
    input  logic                ap_clk,
    input  logic                areset,
    input  logic                enable,
    glay_mem_if.arbiter         req_port [`GLAY_NUM_REQ],
    output logic                mem_we,
    output glay_pkg::mem_addr_t mem_addr,
    output glay_pkg::word_t     mem_wdata,
    input  glay_pkg::word_t     mem_rdata
);
    import glay_pkg::*;

    logic [`GLAY_NUM_REQ-1:0] req_vec;
    logic [`GLAY_NUM_REQ-1:0] we_vec;
    mem_addr_t                addr_vec  [`GLAY_NUM_REQ];
    word_t                    wdata_vec [`GLAY_NUM_REQ];
    logic [`GLAY_NUM_REQ-1:0] grant_c;
    logic [`GLAY_NUM_REQ-1:0] grant_q;
    logic [`GLAY_NUM_REQ-1:0] rd_p1;
    logic [`GLAY_NUM_REQ-1:0] rd_p2;
    eng_sel_t                 sel;
    logic                     sel_valid;
    logic                     enable_reg;
    word_t                    rdata_q;

    // --------------------
    // unpack the interface array
    for (genvar i = 0; i < `GLAY_NUM_REQ; i++) begin : g_port
        assign req_vec[i]          = req_port[i].req;
        assign we_vec[i]           = req_port[i].we;
        assign addr_vec[i]         = req_port[i].addr;
        assign wdata_vec[i]        = req_port[i].wdata;
        assign req_port[i].grant   = grant_q[i] & req_port[i].req;
        assign req_port[i].rvalid  = rd_p2[i];
        assign req_port[i].rdata   = rdata_q;
    end

    // the cycle a port is granted, its held request is not seen again
    rr_arbiter i_rr_arbiter (
        .ap_clk (ap_clk),
        .areset (areset),
        .enable (enable_reg),
        .req    (req_vec & ~grant_q),
        .grant  (grant_c),
        .select (sel),
        .valid  (sel_valid)
    );

    // --------------------
    // control path
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            enable_reg <= 1'b0;
            grant_q    <= '0;
            mem_we     <= 1'b0;
            rd_p1      <= '0;
            rd_p2      <= '0;
        end else begin
            enable_reg <= enable;
            grant_q    <= grant_c;
            mem_we     <= sel_valid & we_vec[sel];
            // reads only, writes finish at grant
            rd_p1      <= mem_we ? '0 : grant_q;
            rd_p2      <= rd_p1;
        end
    end

    // bus payload, zeroed when nobody wins
    always_ff @(posedge ap_clk) begin
        if (sel_valid) begin
            mem_addr  <= addr_vec[sel];
            mem_wdata <= wdata_vec[sel];
        end else begin
            mem_addr  <= '0;
            mem_wdata <= '0;
        end
        // second stage of the read, lines up with rd_p2
        rdata_q <= mem_rdata;
    end

    // no write reaches the ram unless a port holds the bus
    a_we_needs_grant : assert property (
        @(posedge ap_clk) disable iff (areset)
        mem_we |-> (|grant_q)
    );

endmodule : bus_arbiter_n_in_1_out

//--- verilog/edge_mem.sv
// single-port edge-weight ram, read-before-write
// contents are undefined until written by the host
`include "glay_params.svh"

module edge_mem (
    input  logic                ap_clk,
    input  logic                en,
    input  logic                we,
    input  glay_pkg::mem_addr_t addr,
    input  glay_pkg::word_t     wdata,
    output glay_pkg::word_t     rdata
);
    import glay_pkg::*;

    word_t ram [2**`GLAY_MEM_AW];

    // one-cycle registered read
    always_ff @(posedge ap_clk) begin
        if (en) begin
            if (we) begin
                ram[addr] <= wdata;
            end
            rdata <= ram[addr];
        end
    end

endmodule : edge_mem

//--- verilog/edge_sum_engine.sv
// sums length words from base, addresses wrap at the top of the memory
// start is ignored while busy; sum wraps modulo 2**32

module edge_sum_engine (
    input  logic                ap_clk,
    input  logic                areset,
    input  logic                start,
    input  glay_pkg::mem_addr_t base,
    input  glay_pkg::mem_addr_t length,
    glay_mem_if.requester       mem,
    output logic                done,
    output glay_pkg::word_t     sum
);
    import glay_pkg::*;

    eng_state_t state;
    // next word to read
    mem_addr_t  addr_q;
    // words still to add
    mem_addr_t  left_q;

    // read-only requester
    assign mem.req   = (state == eng_issue);
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;
    assign done      = (state == eng_done);

    always_ff @(posedge ap_clk) begin
        if (areset) begin
            state  <= eng_idle;
            sum    <= '0;
            addr_q <= '0;
            left_q <= '0;
        end else begin
            case (state)
                eng_idle, eng_done: begin
                    if (start) begin
                        sum    <= '0;
                        addr_q <= base;
                        left_q <= length;
                        // empty range goes straight to done
                        state  <= (length == '0) ? eng_done : eng_issue;
                    end
                end
                eng_issue: begin
                    // req drops the cycle after grant
                    if (mem.grant) begin
                        state <= eng_wait_data;
                    end
                end
                eng_wait_data: begin
                    if (mem.rvalid) begin
                        sum    <= sum + mem.rdata;
                        addr_q <= addr_q + 1'b1;
                        left_q <= left_q - 1'b1;
                        state  <= (left_q == 1) ? eng_done : eng_issue;
                    end
                end
                default: state <= eng_idle;
            endcase
        end
    end

    // a pending request keeps its address
    a_addr_hold : assert property (
        @(posedge ap_clk) disable iff (areset)
        (mem.req && !mem.grant) |=> $stable(mem.addr)
    );

endmodule : edge_sum_engine

//--- verilog/glay_ctrl_axil.sv
// axi4-lite slave, one transaction at a time, every response okay
// register accesses answer in 2 cycles, memory-window accesses wait on the arbiter
`include "glay_params.svh"

module glay_ctrl_axil (
    input  logic                         ap_clk,
    input  logic                         areset,
    input  glay_pkg::axi_addr_t          awaddr,
    input  logic                         awvalid,
    output logic                         awready,
    input  glay_pkg::word_t              wdata,
    input  logic                         wvalid,
    output logic                         wready,
    output logic [1:0]                   bresp,
    output logic                         bvalid,
    input  logic                         bready,
    input  glay_pkg::axi_addr_t          araddr,
    input  logic                         arvalid,
    output logic                         arready,
    output glay_pkg::word_t              rdata,
    output logic [1:0]                   rresp,
    output logic                         rvalid,
    input  logic                         rready,
    output logic [`GLAY_NUM_ENGINES-1:0] start,
    output glay_pkg::mem_addr_t          base   [`GLAY_NUM_ENGINES],
    output glay_pkg::mem_addr_t          length [`GLAY_NUM_ENGINES],
    input  logic [`GLAY_NUM_ENGINES-1:0] done,
    input  glay_pkg::word_t              sum    [`GLAY_NUM_ENGINES],
    glay_mem_if.requester                mem
);
    import glay_pkg::*;

    ctrl_state_t state;
    axi_addr_t   addr_q;
    word_t       wdata_q;
    logic        is_wr;
    logic        is_mem;
    // memory request already granted
    logic        issued;
    logic [1:0]  eng_idx;
    logic [1:0]  reg_off;
    logic        reg_hit;
    word_t       reg_rdata;

    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // --------------------
    // register decode, 16 bytes per engine
    assign eng_idx = addr_q[5:4];
    assign reg_off = addr_q[3:2];
    assign reg_hit = (addr_q[`GLAY_MEM_WIN_BIT-1:6] == '0) && (eng_idx < `GLAY_NUM_ENGINES);

    always_comb begin
        reg_rdata = '0;
        if (reg_hit) begin
            case (reg_off)
                2'd0:    reg_rdata = word_t'(base[eng_idx]);
                2'd1:    reg_rdata = word_t'(length[eng_idx]);
                2'd2:    reg_rdata = word_t'(done[eng_idx]);
                default: reg_rdata = sum[eng_idx];
            endcase
        end
    end

    // memory window, word address from bits 9:2
    assign mem.req   = (state == ctrl_mem_wait) && is_mem && !issued;
    assign mem.we    = is_wr;
    assign mem.addr  = addr_q[`GLAY_MEM_AW+1:2];
    assign mem.wdata = wdata_q;

    // --------------------
    // transaction FSM
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            state   <= ctrl_idle;
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            start   <= '0;
            is_wr   <= 1'b0;
            is_mem  <= 1'b0;
            issued  <= 1'b0;
            for (int e = 0; e < `GLAY_NUM_ENGINES; e++) begin
                base[e]   <= '0;
                length[e] <= '0;
            end
        end else begin
            // ready and start are single-cycle pulses
            awready <= 1'b0;
            wready  <= 1'b0;
            arready <= 1'b0;
            start   <= '0;
            case (state)
                ctrl_idle: begin
                    issued <= 1'b0;
                    // writes win over reads
                    if (awvalid && wvalid) begin
                        awready <= 1'b1;
                        wready  <= 1'b1;
                        is_wr   <= 1'b1;
                        is_mem  <= awaddr[`GLAY_MEM_WIN_BIT];
                        state   <= ctrl_mem_wait;
                    end else if (arvalid) begin
                        arready <= 1'b1;
                        is_wr   <= 1'b0;
                        is_mem  <= araddr[`GLAY_MEM_WIN_BIT];
                        state   <= ctrl_mem_wait;
                    end
                end
                ctrl_mem_wait: begin
                    if (!is_mem) begin
                        // register access, done in this one cycle
                        if (is_wr) begin
                            bvalid <= 1'b1;
                            if (reg_hit) begin
                                case (reg_off)
                                    2'd0:    base[eng_idx]   <= wdata_q[`GLAY_MEM_AW-1:0];
                                    2'd1:    length[eng_idx] <= wdata_q[`GLAY_MEM_AW-1:0];
                                    2'd2:    start[eng_idx]  <= 1'b1;
                                    default: ;
                                endcase
                            end
                        end else begin
                            rvalid <= 1'b1;
                        end
                        state <= ctrl_resp;
                    end else if (mem.grant && is_wr) begin
                        bvalid <= 1'b1;
                        state  <= ctrl_resp;
                    end else if (mem.grant) begin
                        issued <= 1'b1;
                    end else if (mem.rvalid) begin
                        rvalid <= 1'b1;
                        state  <= ctrl_resp;
                    end
                end
                ctrl_resp: begin
                    // hold the response until the master takes it
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                        state  <= ctrl_idle;
                    end
                end
                default: state <= ctrl_idle;
            endcase
        end
    end

    // --------------------
    // captured request and read data
    always_ff @(posedge ap_clk) begin
        if (state == ctrl_idle) begin
            if (awvalid && wvalid) begin
                addr_q  <= awaddr;
                wdata_q <= wdata;
            end else if (arvalid) begin
                addr_q <= araddr;
            end
        end
        // last update lands with mem.rvalid, then frozen in resp
        if (state == ctrl_mem_wait) begin
            rdata <= is_mem ? mem.rdata : reg_rdata;
        end
    end

endmodule : glay_ctrl_axil

//--- verilog/glay_top.sv
// engines take requester ports 0..N-1, the host bridge takes the last one
// arbiter is always enabled, the ram is always selected
`include "glay_params.svh"

module glay_top (
    input  logic                ap_clk,
    input  logic                areset,
    input  glay_pkg::axi_addr_t awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  glay_pkg::word_t     wdata,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  glay_pkg::axi_addr_t araddr,
    input  logic                arvalid,
    output logic                arready,
    output glay_pkg::word_t     rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready
);
    import glay_pkg::*;

    logic [`GLAY_NUM_ENGINES-1:0] eng_start;
    mem_addr_t                    eng_base   [`GLAY_NUM_ENGINES];
    mem_addr_t                    eng_length [`GLAY_NUM_ENGINES];
    logic [`GLAY_NUM_ENGINES-1:0] eng_done;
    word_t                        eng_sum    [`GLAY_NUM_ENGINES];
    logic                         mem_we;
    mem_addr_t                    mem_addr;
    word_t                        mem_wdata;
    word_t                        mem_rdata;

    glay_mem_if mem_bus [`GLAY_NUM_REQ] ();

    glay_ctrl_axil i_ctrl (
        .ap_clk  (ap_clk),
        .areset  (areset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .start   (eng_start),
        .base    (eng_base),
        .length  (eng_length),
        .done    (eng_done),
        .sum     (eng_sum),
        .mem     (mem_bus[`GLAY_NUM_ENGINES])
    );

    for (genvar e = 0; e < `GLAY_NUM_ENGINES; e++) begin : g_eng
        edge_sum_engine i_eng (
            .ap_clk (ap_clk),
            .areset (areset),
            .start  (eng_start[e]),
            .base   (eng_base[e]),
            .length (eng_length[e]),
            .mem    (mem_bus[e]),
            .done   (eng_done[e]),
            .sum    (eng_sum[e])
        );
    end

    bus_arbiter_n_in_1_out i_arb (
        .ap_clk    (ap_clk),
        .areset    (areset),
        .enable    (1'b1),
        .req_port  (mem_bus),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    edge_mem i_mem (
        .ap_clk (ap_clk),
        .en     (1'b1),
        .we     (mem_we),
        .addr   (mem_addr),
        .wdata  (mem_wdata),
        .rdata  (mem_rdata)
    );

endmodule : glay_top

//--- test/tb_glay_top.sv
// testbench for glay_top, replays axi4-lite commands from test/glay_stim.txt
// run from the project root so the stim path resolves
`include "glay_params.svh"

module tb_glay_top;
    import glay_pkg::*;

    // cycles any single wait may take
    localparam int TIMEOUT = 200;
    // done reads per poll command
    localparam int POLL_MAX = 100;

    logic       ap_clk;
    logic       areset;
    axi_addr_t  awaddr;
    logic       awvalid;
    logic       awready;
    word_t      wdata;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;
    axi_addr_t  araddr;
    logic       arvalid;
    logic       arready;
    word_t      rdata;
    logic [1:0] rresp;
    logic       rvalid;
    logic       rready;

    int err_cnt;
    int tmo_cnt;
    int chk_cnt;

    glay_top i_glay_top (
        .ap_clk  (ap_clk),
        .areset  (areset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // --------------------
    // one clock, landing 1 unit after the edge where outputs are settled
    task automatic next_cycle();
        @(posedge ap_clk);
        #1;
    endtask

    // 0 to 3 idle cycles before bready or rready
    task automatic random_delay();
        int n;
        n = $urandom % 4;
        repeat (n) next_cycle();
    endtask

    task automatic axi_write(input axi_addr_t addr, input word_t data);
        int cnt;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        cnt     = 0;
        while (!awready && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        assert (awready) else begin
            $display("timeout: write to 0x%h never accepted", addr);
            tmo_cnt++;
        end
        // wready pulses in the same cycle as awready
        assert (wready === 1'b1) else begin
            $display("Fail wready: expected 0x1, got 0x%h", wready);
            err_cnt++;
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // response phase
        cnt = 0;
        while (!bvalid && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        assert (bvalid) else begin
            $display("timeout: no write response for 0x%h", addr);
            tmo_cnt++;
        end
        if (bvalid) begin
            random_delay();
            assert (bresp === 2'b00) else begin
                $display("Fail bresp: expected 0x0, got 0x%h", bresp);
                err_cnt++;
            end
            bready = 1'b1;
            next_cycle();
            bready = 1'b0;
            // a second response here would be a duplicate
            assert (!bvalid) else begin
                $display("write response for 0x%h still valid after handshake", addr);
                err_cnt++;
            end
        end
    endtask

    task automatic axi_read(input axi_addr_t addr, output word_t data);
        int cnt;
        data    = '0;
        araddr  = addr;
        arvalid = 1'b1;
        cnt     = 0;
        while (!arready && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        assert (arready) else begin
            $display("timeout: read of 0x%h never accepted", addr);
            tmo_cnt++;
        end
        arvalid = 1'b0;
        cnt     = 0;
        while (!rvalid && cnt < TIMEOUT) begin
            next_cycle();
            cnt++;
        end
        assert (rvalid) else begin
            $display("timeout: no read data for 0x%h", addr);
            tmo_cnt++;
        end
        if (rvalid) begin
            random_delay();
            // rdata is held while rvalid waits
            data = rdata;
            assert (rresp === 2'b00) else begin
                $display("Fail rresp: expected 0x0, got 0x%h", rresp);
                err_cnt++;
            end
            rready = 1'b1;
            next_cycle();
            rready = 1'b0;
            assert (!rvalid) else begin
                $display("read data for 0x%h still valid after handshake", addr);
                err_cnt++;
            end
        end
    endtask

    task automatic check_read(input axi_addr_t addr, input word_t exp);
        word_t got;
        axi_read(addr, got);
        chk_cnt++;
        assert (got === exp) else begin
            $display("Fail rdata at 0x%h: expected 0x%h, got 0x%h", addr, exp, got);
            err_cnt++;
        end
    endtask

    // done flag sits at offset 0x8 of the engine's 16-byte block
    task automatic poll_done(input int eng);
        word_t val;
        int    n;
        val = '0;
        n   = 0;
        while (val[0] !== 1'b1 && n < POLL_MAX) begin
            axi_read(axi_addr_t'(16 * eng + 8), val);
            n++;
        end
        assert (val[0] === 1'b1) else begin
            $display("timeout: engine %0d never reported done", eng);
            tmo_cnt++;
        end
    endtask

    // --------------------
    initial begin
        int              fd;
        int              code;
        logic [7:0]      cmd;
        logic [8*128-1:0] line;
        axi_addr_t       addr;
        word_t           data;
        int              eng;
        areset  = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        err_cnt = 0;
        tmo_cnt = 0;
        chk_cnt = 0;
        void'($urandom(59));
        repeat (10) @(posedge ap_clk);
        #1;
        areset = 1'b0;
        next_cycle();

        fd = $fopen("test/glay_stim.txt", "r");
        assert (fd != 0) else begin
            $display("could not open test/glay_stim.txt");
            err_cnt++;
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", cmd);
                if (code != 1) begin
                    break;
                end
                case (cmd)
                    "#": code = $fgets(line, fd);
                    "W": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        axi_write(addr, data);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        check_read(addr, data);
                    end
                    "P": begin
                        code = $fscanf(fd, "%d", eng);
                        poll_done(eng);
                    end
                    default: begin
                        $display("unknown command in stim file: %c", cmd);
                        err_cnt++;
                    end
                endcase
            end
            $fclose(fd);
        end

        repeat (4) next_cycle();
        $display("errors: %0d, timeouts: %0d, reads checked: %0d", err_cnt, tmo_cnt, chk_cnt);
        if (err_cnt == 0 && tmo_cnt == 0 && chk_cnt > 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : tb_glay_top

//--- build.f
+incdir+verilog
verilog/glay_pkg.sv
verilog/glay_mem_if.sv
verilog/rr_arbiter.sv
verilog/bus_arbiter_n_in_1_out.sv
verilog/edge_mem.sv
verilog/edge_sum_engine.sv
verilog/glay_ctrl_axil.sv
verilog/glay_top.sv
test/tb_glay_top.sv

//--- Bender.yml
package:
  name: glay

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/glay_pkg.sv
      - verilog/glay_mem_if.sv
      - verilog/rr_arbiter.sv
      - verilog/bus_arbiter_n_in_1_out.sv
      - verilog/edge_mem.sv
      - verilog/edge_sum_engine.sv
      - verilog/glay_ctrl_axil.sv
      - verilog/glay_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_glay_top.sv

//--- test/glay_stim.txt
# cmd addr data: W = write data to addr, R = read addr and expect data, P n = poll engine n done
# addr and data in hex; engine e regs at 16*e (+0 base, +4 length, +8 start/done, +C sum)
# after reset, done and sum are zero
R 0008 00000000
R 000C 00000000
R 0018 00000000
R 001C 00000000
R 0028 00000000
R 002C 00000000
# edge weights, memory window is 0x1000 + 4 * word
W 1000 00000001
W 1004 00000002
W 1008 00000003
W 100C 00000004
W 1010 FFFFFFFF
W 1014 80000000
W 13F8 10000000
W 13FC F0000000
R 1000 00000001
R 13FC F0000000
R 13F8 10000000
# disjoint ranges, started back to back
W 0000 00000000
W 0004 00000002
W 0010 00000002
W 0014 00000002
W 0020 00000004
W 0024 00000002
W 0008 00000001
W 0018 00000001
W 0028 00000001
P 0
P 1
P 2
R 000C 00000003
R 001C 00000007
R 002C 7FFFFFFF
# overlapping ranges with host reads while the engines run
W 0004 00000006
W 0010 00000001
W 0014 00000004
W 0008 00000001
W 0018 00000001
R 1004 00000002
R 1010 FFFFFFFF
R 1014 80000000
P 0
P 1
R 000C 80000009
R 001C 00000008
# empty range, then words 0xFE 0xFF 0x00 0x01
W 0024 00000000
W 0028 00000001
P 2
R 002C 00000000
W 0010 000000FE
W 0014 00000004
R 0010 000000FE
W 0018 00000001
P 1
R 001C 00000003
R 000C 80000009
